// File: issue_pkg.sv
`default_nettype none

package issue_pkg;

    // Register index width for 32 architectural registers
    localparam int reg_idx_w = 5;

    // Load/store offset carried to the address generator
    localparam int lsp_offset_w = 12;

    // Operand 1 select codes
    localparam logic [1:0] opr1_pc   = 2'd0;
    localparam logic [1:0] opr1_rs1  = 2'd1;
    localparam logic [1:0] opr1_zero = 2'd2;
    localparam logic [1:0] opr1_zimm = 2'd3;

    // Operand 2 select codes
    localparam logic [1:0] opr2_rs2  = 2'd0;
    localparam logic [1:0] opr2_imm  = 2'd1;
    localparam logic [1:0] opr2_four = 2'd2;

    // Op types handled by this stage
    // Any other code stays in decode
    localparam logic [2:0] ot_int   = 3'd0;
    localparam logic [2:0] ot_load  = 3'd1;
    localparam logic [2:0] ot_store = 3'd2;

endpackage

`default_nettype wire

// File: operand_if.sv
`timescale 1ns/1ns
`default_nettype none

interface operand_if #(
    parameter int xlen = 64
);

    // Resolved source values
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;

    // Low while a producer is still in flight
    logic rs1_ready;
    logic rs2_ready;

    modport fwd (
        output rs1_val, rs2_val, rs1_ready, rs2_ready
    );

    modport ctrl (
        input rs1_val, rs2_val, rs1_ready, rs2_ready
    );

endinterface

`default_nettype wire

// File: operand_forward.sv
`timescale 1ns/1ns
`default_nettype none

module operand_forward #(
    parameter int xlen = 64
) (
    // Register file read data
    input  logic [xlen-1:0]                   rf_rdata0,
    input  logic [xlen-1:0]                   rf_rdata1,
    input  logic [issue_pkg::reg_idx_w-1:0]   dec_rs1,
    input  logic [issue_pkg::reg_idx_w-1:0]   dec_rs2,
    // Integer writeback
    input  logic [issue_pkg::reg_idx_w-1:0]   ip_wb_dst,
    input  logic [xlen-1:0]                   ip_wb_result,
    input  logic                              ip_wb_wb_en,
    input  logic                              ip_wb_valid,
    // Integer execute result
    input  logic [xlen-1:0]                   ip_ix_forwarding,
    // Integer slot status
    input  logic                              ip_valid,
    input  logic                              ip_ready,
    input  logic                              ip_wb_en,
    input  logic [issue_pkg::reg_idx_w-1:0]   ip_dst,
    // Load/store writeback
    input  logic [issue_pkg::reg_idx_w-1:0]   lsp_wb_dst,
    input  logic [xlen-1:0]                   lsp_wb_result,
    input  logic                              lsp_wb_wb_en,
    input  logic                              lsp_wb_valid,
    // Load in memory access
    input  logic                              lsp_mem_wb_en,
    input  logic [issue_pkg::reg_idx_w-1:0]   lsp_mem_dst,
    // Load/store slot status
    input  logic                              lsp_valid,
    input  logic                              lsp_wb_en,
    input  logic [issue_pkg::reg_idx_w-1:0]   lsp_dst,
    operand_if.fwd                            opnd
);

    logic [issue_pkg::reg_idx_w-1:0] src_idx [2];
    logic [xlen-1:0]                 src_rdata [2];
    logic [xlen-1:0]                 src_val [2];
    logic                            src_ready [2];

    // Which in-flight stages hold a result headed for the register file
    logic ip_wb_active;
    logic ip_ex_active;
    logic ip_ex_stalled;
    logic lsp_wb_active;
    logic lsp_ag_active;

    assign ip_wb_active  = ip_wb_valid && ip_wb_wb_en;
    assign ip_ex_active  = ip_valid && ip_ready && ip_wb_en;
    assign ip_ex_stalled = ip_valid && !ip_ready && ip_wb_en;
    assign lsp_wb_active = lsp_wb_valid && lsp_wb_wb_en;
    assign lsp_ag_active = lsp_valid && lsp_wb_en;

    assign src_idx[0]   = dec_rs1;
    assign src_idx[1]   = dec_rs2;
    assign src_rdata[0] = rf_rdata0;
    assign src_rdata[1] = rf_rdata1;

    for (genvar i = 0; i < 2; i++) begin : g_src
        logic [xlen-1:0] val;
        logic            rdy;

        // Later checks win over earlier ones
        always_comb begin
            val = src_rdata[i];
            rdy = 1'b1;
            if (ip_wb_active && (ip_wb_dst == src_idx[i])) begin
                val = ip_wb_result;
            end
            if (ip_ex_active && (ip_dst == src_idx[i])) begin
                val = ip_ix_forwarding;
            end
            if (ip_ex_stalled && (ip_dst == src_idx[i])) begin
                rdy = 1'b0;
            end
            if (lsp_wb_active && (lsp_wb_dst == src_idx[i])) begin
                val = lsp_wb_result;
                rdy = 1'b1;
            end
            if (lsp_mem_wb_en && (lsp_mem_dst == src_idx[i])) begin
                rdy = 1'b0;
            end
            if (lsp_ag_active && (lsp_dst == src_idx[i])) begin
                rdy = 1'b0;
            end
            // x0 ignores any forwarded write
            if (src_idx[i] == '0) begin
                val = '0;
                rdy = 1'b1;
            end
        end

        assign src_val[i]   = val;
        assign src_ready[i] = rdy;
    end

    assign opnd.rs1_val   = src_val[0];
    assign opnd.rs2_val   = src_val[1];
    assign opnd.rs1_ready = src_ready[0];
    assign opnd.rs2_ready = src_ready[1];

    always_comb begin
        assert ((dec_rs1 != '0) || opnd.rs1_ready)
            else $error("operand_forward: x0 reported not ready on rs1");
        assert ((dec_rs2 != '0) || opnd.rs2_ready)
            else $error("operand_forward: x0 reported not ready on rs2");
    end

endmodule

`default_nettype wire

// File: issue_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module issue_ctrl #(
    parameter int xlen = 64,
    parameter int ip_payload_w = 3 * xlen + issue_pkg::reg_idx_w + 7,
    parameter int lsp_payload_w = 3 * xlen + issue_pkg::reg_idx_w +
            issue_pkg::lsp_offset_w + 4
) (
    input  logic                              rst,
    input  logic                              dec_valid,
    input  logic                              pipe_flush,
    input  logic [xlen-1:0]                   dec_pc,
    input  logic [3:0]                        dec_op,
    input  logic                              dec_option,
    input  logic                              dec_truncate,
    input  logic                              dec_mem_sign,
    input  logic [1:0]                        dec_mem_width,
    input  logic [2:0]                        dec_op_type,
    input  logic [1:0]                        dec_operand1,
    input  logic [1:0]                        dec_operand2,
    input  logic [xlen-1:0]                   dec_imm,
    input  logic                              dec_wb_en,
    input  logic [issue_pkg::reg_idx_w-1:0]   dec_rs1,
    input  logic [issue_pkg::reg_idx_w-1:0]   dec_rd,
    input  logic                              ip_ready,
    input  logic                              lsp_ready,
    input  logic                              lsp_mem_wb_en,
    input  logic [issue_pkg::reg_idx_w-1:0]   lsp_mem_dst,
    input  logic                              lsp_valid,
    input  logic                              lsp_wb_en,
    input  logic [issue_pkg::reg_idx_w-1:0]   lsp_dst,
    operand_if.ctrl                           opnd,
    output logic                              dec_ready,
    output logic                              ip_issue,
    output logic                              lsp_issue,
    output logic [ip_payload_w-1:0]           ip_payload,
    output logic [lsp_payload_w-1:0]          lsp_payload
);

    logic [xlen-1:0] operand1;
    logic [xlen-1:0] operand2;
    logic            opr1_ready;
    logic            opr2_ready;
    logic            is_int;
    logic            is_mem;
    logic            waw_clear;
    logic            issue_common;

    always_comb begin
        case (dec_operand1)
            issue_pkg::opr1_pc:   operand1 = dec_pc;
            issue_pkg::opr1_rs1:  operand1 = opnd.rs1_val;
            issue_pkg::opr1_zimm: operand1 = {{(xlen - issue_pkg::reg_idx_w){1'b0}}, dec_rs1};
            default:              operand1 = '0;
        endcase
        case (dec_operand2)
            issue_pkg::opr2_rs2:  operand2 = opnd.rs2_val;
            issue_pkg::opr2_imm:  operand2 = dec_imm;
            issue_pkg::opr2_four: operand2 = xlen'(4);
            default:              operand2 = '0;
        endcase
    end

    // Only a register operand can hold up issue
    assign opr1_ready = (dec_operand1 == issue_pkg::opr1_rs1) ? opnd.rs1_ready : 1'b1;
    assign opr2_ready = (dec_operand2 == issue_pkg::opr2_rs2) ? opnd.rs2_ready : 1'b1;

    assign is_int = (dec_op_type == issue_pkg::ot_int);
    assign is_mem = (dec_op_type == issue_pkg::ot_load) ||
            (dec_op_type == issue_pkg::ot_store);

    // Integer results retire ahead of a pending load, so wait for it
    assign waw_clear = (!lsp_mem_wb_en || (lsp_mem_dst != dec_rd)) &&
            (!lsp_valid || !lsp_wb_en || (lsp_dst != dec_rd));

    assign issue_common = dec_valid && opr1_ready && opr2_ready && !pipe_flush;
    assign ip_issue     = issue_common && ip_ready && is_int && waw_clear;
    assign lsp_issue    = issue_common && lsp_ready && is_mem;

    // A flush consumes whatever decode is presenting
    assign dec_ready = !rst && !(dec_valid && !ip_issue && !lsp_issue && !pipe_flush);

    assign ip_payload = {dec_pc, dec_rd, dec_wb_en, dec_op, dec_option, dec_truncate,
            operand1, operand2};

    assign lsp_payload = {dec_pc, dec_rd, dec_wb_en, operand1,
            dec_imm[issue_pkg::lsp_offset_w-1:0], operand2, dec_mem_sign, dec_mem_width};

    always_comb begin
        assert (!(ip_issue && lsp_issue))
            else $error("issue_ctrl: instruction routed to both pipes");
    end

endmodule

`default_nettype wire

// File: issue_slot.sv
`timescale 1ns/1ns
`default_nettype none

module issue_slot #(
    parameter int payload_w = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue,
    input  logic                 flush,
    input  logic [payload_w-1:0] payload_in,
    input  logic                 ready,
    output logic                 valid,
    output logic [payload_w-1:0] payload
);

    // Packet stays put until the pipe takes it
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (issue) begin
            valid <= 1'b1;
        end else if (ready || flush) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            payload <= payload_in;
        end
    end

    // Issue logic upstream must respect back-pressure
    assert property (@(posedge clk) disable iff (rst) !(issue && valid && !ready))
        else $error("issue_slot: held packet overwritten by new issue");

endmodule

`default_nettype wire

// File: issue_stage.sv
`timescale 1ns/1ns
`default_nettype none

module issue_stage #(
    parameter int xlen = 64
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              pipe_flush,
    // Register file
    output logic [issue_pkg::reg_idx_w-1:0]   rf_rsrc0,
    input  logic [xlen-1:0]                   rf_rdata0,
    output logic [issue_pkg::reg_idx_w-1:0]   rf_rsrc1,
    input  logic [xlen-1:0]                   rf_rdata1,
    // Decoded instruction
    input  logic [xlen-1:0]                   dec_pc,
    input  logic [3:0]                        dec_op,
    input  logic                              dec_option,
    input  logic                              dec_truncate,
    input  logic                              dec_mem_sign,
    input  logic [1:0]                        dec_mem_width,
    input  logic [2:0]                        dec_op_type,
    input  logic [1:0]                        dec_operand1,
    input  logic [1:0]                        dec_operand2,
    input  logic [xlen-1:0]                   dec_imm,
    input  logic                              dec_wb_en,
    input  logic [issue_pkg::reg_idx_w-1:0]   dec_rs1,
    input  logic [issue_pkg::reg_idx_w-1:0]   dec_rs2,
    input  logic [issue_pkg::reg_idx_w-1:0]   dec_rd,
    input  logic                              dec_valid,
    output logic                              dec_ready,
    // Integer pipe
    output logic [xlen-1:0]                   ix_ip_pc,
    output logic [issue_pkg::reg_idx_w-1:0]   ix_ip_dst,
    output logic                              ix_ip_wb_en,
    output logic [3:0]                        ix_ip_op,
    output logic                              ix_ip_option,
    output logic                              ix_ip_truncate,
    output logic [xlen-1:0]                   ix_ip_operand1,
    output logic [xlen-1:0]                   ix_ip_operand2,
    output logic                              ix_ip_valid,
    input  logic                              ix_ip_ready,
    // Forwarding sources
    input  logic [xlen-1:0]                   ip_ix_forwarding,
    input  logic [issue_pkg::reg_idx_w-1:0]   ip_wb_dst,
    input  logic [xlen-1:0]                   ip_wb_result,
    input  logic                              ip_wb_wb_en,
    input  logic                              ip_wb_valid,
    input  logic [issue_pkg::reg_idx_w-1:0]   lsp_wb_dst,
    input  logic [xlen-1:0]                   lsp_wb_result,
    input  logic                              lsp_wb_wb_en,
    input  logic                              lsp_wb_valid,
    input  logic                              lsp_mem_wb_en,
    input  logic [issue_pkg::reg_idx_w-1:0]   lsp_mem_dst,
    // Load/store pipe
    output logic [xlen-1:0]                   ix_lsp_pc,
    output logic [issue_pkg::reg_idx_w-1:0]   ix_lsp_dst,
    output logic                              ix_lsp_wb_en,
    output logic [xlen-1:0]                   ix_lsp_base,
    output logic [issue_pkg::lsp_offset_w-1:0] ix_lsp_offset,
    output logic [xlen-1:0]                   ix_lsp_source,
    output logic                              ix_lsp_mem_sign,
    output logic [1:0]                        ix_lsp_mem_width,
    output logic                              ix_lsp_valid,
    input  logic                              ix_lsp_ready
);

    // Sum of the packed fields of each slot packet
    localparam int ip_payload_w = 3 * xlen + issue_pkg::reg_idx_w + 7;
    localparam int lsp_payload_w = 3 * xlen + issue_pkg::reg_idx_w +
            issue_pkg::lsp_offset_w + 4;

    logic                     ip_issue;
    logic                     lsp_issue;
    logic [ip_payload_w-1:0]  ip_payload_in;
    logic [ip_payload_w-1:0]  ip_payload;
    logic [lsp_payload_w-1:0] lsp_payload_in;
    logic [lsp_payload_w-1:0] lsp_payload;

    operand_if #(.xlen(xlen)) u_opnd ();

    assign rf_rsrc0 = dec_rs1;
    assign rf_rsrc1 = dec_rs2;

    operand_forward #(.xlen(xlen)) u_operand_forward (
        .rf_rdata0(rf_rdata0), .rf_rdata1(rf_rdata1),
        .dec_rs1(dec_rs1), .dec_rs2(dec_rs2),
        .ip_wb_dst(ip_wb_dst), .ip_wb_result(ip_wb_result),
        .ip_wb_wb_en(ip_wb_wb_en), .ip_wb_valid(ip_wb_valid),
        .ip_ix_forwarding(ip_ix_forwarding),
        .ip_valid(ix_ip_valid), .ip_ready(ix_ip_ready),
        .ip_wb_en(ix_ip_wb_en), .ip_dst(ix_ip_dst),
        .lsp_wb_dst(lsp_wb_dst), .lsp_wb_result(lsp_wb_result),
        .lsp_wb_wb_en(lsp_wb_wb_en), .lsp_wb_valid(lsp_wb_valid),
        .lsp_mem_wb_en(lsp_mem_wb_en), .lsp_mem_dst(lsp_mem_dst),
        .lsp_valid(ix_lsp_valid), .lsp_wb_en(ix_lsp_wb_en), .lsp_dst(ix_lsp_dst),
        .opnd(u_opnd.fwd)
    );

    issue_ctrl #(
        .xlen(xlen), .ip_payload_w(ip_payload_w), .lsp_payload_w(lsp_payload_w)
    ) u_issue_ctrl (
        .rst(rst), .dec_valid(dec_valid), .pipe_flush(pipe_flush),
        .dec_pc(dec_pc), .dec_op(dec_op), .dec_option(dec_option),
        .dec_truncate(dec_truncate), .dec_mem_sign(dec_mem_sign),
        .dec_mem_width(dec_mem_width), .dec_op_type(dec_op_type),
        .dec_operand1(dec_operand1), .dec_operand2(dec_operand2),
        .dec_imm(dec_imm), .dec_wb_en(dec_wb_en), .dec_rs1(dec_rs1), .dec_rd(dec_rd),
        .ip_ready(ix_ip_ready), .lsp_ready(ix_lsp_ready),
        .lsp_mem_wb_en(lsp_mem_wb_en), .lsp_mem_dst(lsp_mem_dst),
        .lsp_valid(ix_lsp_valid), .lsp_wb_en(ix_lsp_wb_en), .lsp_dst(ix_lsp_dst),
        .opnd(u_opnd.ctrl), .dec_ready(dec_ready),
        .ip_issue(ip_issue), .lsp_issue(lsp_issue),
        .ip_payload(ip_payload_in), .lsp_payload(lsp_payload_in)
    );

    issue_slot #(.payload_w(ip_payload_w)) u_ip_slot (
        .clk(clk), .rst(rst), .issue(ip_issue), .flush(pipe_flush),
        .payload_in(ip_payload_in), .ready(ix_ip_ready),
        .valid(ix_ip_valid), .payload(ip_payload)
    );

    issue_slot #(.payload_w(lsp_payload_w)) u_lsp_slot (
        .clk(clk), .rst(rst), .issue(lsp_issue), .flush(pipe_flush),
        .payload_in(lsp_payload_in), .ready(ix_lsp_ready),
        .valid(ix_lsp_valid), .payload(lsp_payload)
    );

    assign {ix_ip_pc, ix_ip_dst, ix_ip_wb_en, ix_ip_op, ix_ip_option, ix_ip_truncate,
            ix_ip_operand1, ix_ip_operand2} = ip_payload;

    assign {ix_lsp_pc, ix_lsp_dst, ix_lsp_wb_en, ix_lsp_base, ix_lsp_offset,
            ix_lsp_source, ix_lsp_mem_sign, ix_lsp_mem_width} = lsp_payload;

endmodule

`default_nettype wire

// File: tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int period = 100,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Release just after the last reset edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: issue_checker.sv
`timescale 1ns/1ns
`default_nettype none

module issue_checker #(
    parameter int xlen = 64
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              pipe_flush,
    input  logic [issue_pkg::reg_idx_w-1:0]   rf_rsrc0,
    input  logic [xlen-1:0]                   rf_rdata0,
    input  logic [issue_pkg::reg_idx_w-1:0]   rf_rsrc1,
    input  logic [xlen-1:0]                   rf_rdata1,
    input  logic [xlen-1:0]                   dec_pc,
    input  logic [3:0]                        dec_op,
    input  logic                              dec_option,
    input  logic                              dec_truncate,
    input  logic                              dec_mem_sign,
    input  logic [1:0]                        dec_mem_width,
    input  logic [2:0]                        dec_op_type,
    input  logic [1:0]                        dec_operand1,
    input  logic [1:0]                        dec_operand2,
    input  logic [xlen-1:0]                   dec_imm,
    input  logic                              dec_wb_en,
    input  logic [issue_pkg::reg_idx_w-1:0]   dec_rs1,
    input  logic [issue_pkg::reg_idx_w-1:0]   dec_rs2,
    input  logic [issue_pkg::reg_idx_w-1:0]   dec_rd,
    input  logic                              dec_valid,
    input  logic                              dec_ready,
    input  logic [xlen-1:0]                   ix_ip_pc,
    input  logic [issue_pkg::reg_idx_w-1:0]   ix_ip_dst,
    input  logic                              ix_ip_wb_en,
    input  logic [3:0]                        ix_ip_op,
    input  logic                              ix_ip_option,
    input  logic                              ix_ip_truncate,
    input  logic [xlen-1:0]                   ix_ip_operand1,
    input  logic [xlen-1:0]                   ix_ip_operand2,
    input  logic                              ix_ip_valid,
    input  logic                              ix_ip_ready,
    input  logic [xlen-1:0]                   ip_ix_forwarding,
    input  logic [issue_pkg::reg_idx_w-1:0]   ip_wb_dst,
    input  logic [xlen-1:0]                   ip_wb_result,
    input  logic                              ip_wb_wb_en,
    input  logic                              ip_wb_valid,
    input  logic [issue_pkg::reg_idx_w-1:0]   lsp_wb_dst,
    input  logic [xlen-1:0]                   lsp_wb_result,
    input  logic                              lsp_wb_wb_en,
    input  logic                              lsp_wb_valid,
    input  logic                              lsp_mem_wb_en,
    input  logic [issue_pkg::reg_idx_w-1:0]   lsp_mem_dst,
    input  logic [xlen-1:0]                   ix_lsp_pc,
    input  logic [issue_pkg::reg_idx_w-1:0]   ix_lsp_dst,
    input  logic                              ix_lsp_wb_en,
    input  logic [xlen-1:0]                   ix_lsp_base,
    input  logic [issue_pkg::lsp_offset_w-1:0] ix_lsp_offset,
    input  logic [xlen-1:0]                   ix_lsp_source,
    input  logic                              ix_lsp_mem_sign,
    input  logic [1:0]                        ix_lsp_mem_width,
    input  logic                              ix_lsp_valid,
    input  logic                              ix_lsp_ready,
    output int                                check_count,
    output int                                error_count
);

    localparam int iw = issue_pkg::reg_idx_w;
    localparam int ip_w = 3 * xlen + iw + 7;
    localparam int lsp_w = 3 * xlen + iw + issue_pkg::lsp_offset_w + 4;

    // Expected packets per pipe in issue order
    logic [ip_w-1:0]  ip_q [$];
    logic [lsp_w-1:0] lsp_q [$];
    logic [iw-1:0]    m_ip_dst;
    logic [iw-1:0]    m_lsp_dst;
    logic             m_ip_wb_en;
    logic             m_lsp_wb_en;

    logic [xlen-1:0]  v1;
    logic [xlen-1:0]  v2;
    logic [xlen-1:0]  op1;
    logic [xlen-1:0]  op2;
    logic             r1;
    logic             r2;
    logic             need_ok;
    logic             waw_block;
    logic             ip_go;
    logic             lsp_go;
    logic [ip_w-1:0]  got_ip;
    logic [lsp_w-1:0] got_lsp;

    initial begin
        check_count = 0;
        error_count = 0;
    end

    task automatic expect_bit(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error %0t: %s is %0b, expected %0b", $time, what, got, exp);
        end
    endtask

    // Ordered forwarding rule where later matches override earlier ones
    task automatic resolve(input logic [iw-1:0] idx, input logic [xlen-1:0] rdata,
            output logic [xlen-1:0] val, output logic rdy);
        val = rdata;
        rdy = 1'b1;
        if (ip_wb_valid && ip_wb_wb_en && ip_wb_dst == idx) val = ip_wb_result;
        if (ip_q.size() != 0 && m_ip_wb_en && m_ip_dst == idx) begin
            if (ix_ip_ready) val = ip_ix_forwarding;
            else rdy = 1'b0;
        end
        if (lsp_wb_valid && lsp_wb_wb_en && lsp_wb_dst == idx) begin
            val = lsp_wb_result;
            rdy = 1'b1;
        end
        if (lsp_mem_wb_en && lsp_mem_dst == idx) rdy = 1'b0;
        if (lsp_q.size() != 0 && m_lsp_wb_en && m_lsp_dst == idx) rdy = 1'b0;
        if (idx == '0) begin
            val = '0;
            rdy = 1'b1;
        end
    endtask

    // Inputs and outputs are settled by the falling edge
    always @(negedge clk) begin
        if (rst) begin
            ip_q.delete();
            lsp_q.delete();
            expect_bit(dec_ready, 1'b0, "dec_ready in reset");
        end else begin
            expect_bit(ix_ip_valid, ip_q.size() != 0, "ix_ip_valid");
            expect_bit(ix_lsp_valid, lsp_q.size() != 0, "ix_lsp_valid");
            expect_bit(rf_rsrc0 == dec_rs1 && rf_rsrc1 == dec_rs2, 1'b1, "rf read index");
            resolve(dec_rs1, rf_rdata0, v1, r1);
            resolve(dec_rs2, rf_rdata1, v2, r2);
            case (dec_operand1)
                issue_pkg::opr1_pc:   op1 = dec_pc;
                issue_pkg::opr1_rs1:  op1 = v1;
                issue_pkg::opr1_zimm: op1 = {{(xlen - iw){1'b0}}, dec_rs1};
                default:              op1 = '0;
            endcase
            case (dec_operand2)
                issue_pkg::opr2_rs2:  op2 = v2;
                issue_pkg::opr2_imm:  op2 = dec_imm;
                issue_pkg::opr2_four: op2 = xlen'(4);
                default:              op2 = '0;
            endcase
            need_ok = (dec_operand1 != issue_pkg::opr1_rs1 || r1) &&
                    (dec_operand2 != issue_pkg::opr2_rs2 || r2);
            waw_block = (lsp_mem_wb_en && lsp_mem_dst == dec_rd) ||
                    (lsp_q.size() != 0 && m_lsp_wb_en && m_lsp_dst == dec_rd);
            ip_go = dec_valid && need_ok && !pipe_flush && ix_ip_ready &&
                    dec_op_type == issue_pkg::ot_int && !waw_block;
            lsp_go = dec_valid && need_ok && !pipe_flush && ix_lsp_ready &&
                    (dec_op_type == issue_pkg::ot_load || dec_op_type == issue_pkg::ot_store);
            expect_bit(dec_ready, !(dec_valid && !ip_go && !lsp_go && !pipe_flush), "dec_ready");

            // Integer pipe handshake or flush
            if (ip_q.size() != 0 && ix_ip_ready) begin
                got_ip = {ix_ip_pc, ix_ip_dst, ix_ip_wb_en, ix_ip_op, ix_ip_option,
                        ix_ip_truncate, ix_ip_operand1, ix_ip_operand2};
                check_count++;
                if (got_ip !== ip_q[0]) begin
                    error_count++;
                    $display("error %0t: integer packet %h, expected %h", $time, got_ip, ip_q[0]);
                end
                void'(ip_q.pop_front());
            end else if (ip_q.size() != 0 && pipe_flush) begin
                void'(ip_q.pop_front());
            end
            if (ip_go) begin
                ip_q.push_back({dec_pc, dec_rd, dec_wb_en, dec_op, dec_option, dec_truncate,
                        op1, op2});
                m_ip_dst = dec_rd;
                m_ip_wb_en = dec_wb_en;
            end

            // Load/store pipe handshake or flush
            if (lsp_q.size() != 0 && ix_lsp_ready) begin
                got_lsp = {ix_lsp_pc, ix_lsp_dst, ix_lsp_wb_en, ix_lsp_base, ix_lsp_offset,
                        ix_lsp_source, ix_lsp_mem_sign, ix_lsp_mem_width};
                check_count++;
                if (got_lsp !== lsp_q[0]) begin
                    error_count++;
                    $display("error %0t: load/store packet %h, expected %h",
                            $time, got_lsp, lsp_q[0]);
                end
                void'(lsp_q.pop_front());
            end else if (lsp_q.size() != 0 && pipe_flush) begin
                void'(lsp_q.pop_front());
            end
            if (lsp_go) begin
                lsp_q.push_back({dec_pc, dec_rd, dec_wb_en, op1,
                        dec_imm[issue_pkg::lsp_offset_w-1:0], op2, dec_mem_sign, dec_mem_width});
                m_lsp_dst = dec_rd;
                m_lsp_wb_en = dec_wb_en;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_issue_stage.sv
`timescale 1ns/1ns
`default_nettype none

module tb_issue_stage;

    localparam int xlen = 64;
    localparam int iw = issue_pkg::reg_idx_w;
    localparam int period = 100;
    localparam int reset_cycles = 5;
    localparam int drive_delay = 10;
    localparam int idle_cycles = 20;
    localparam int basic_cycles = 300;
    localparam int fwd_cycles = 500;
    localparam int bp_cycles = 500;
    localparam int flush_cycles = 400;
    localparam int total_cycles = reset_cycles + idle_cycles + basic_cycles + fwd_cycles +
            bp_cycles + flush_cycles;

    logic clk;
    logic rst;
    logic pipe_flush;
    logic [iw-1:0] rf_rsrc0;
    logic [iw-1:0] rf_rsrc1;
    logic [xlen-1:0] rf_rdata0;
    logic [xlen-1:0] rf_rdata1;
    logic [xlen-1:0] dec_pc;
    logic [3:0] dec_op;
    logic dec_option;
    logic dec_truncate;
    logic dec_mem_sign;
    logic [1:0] dec_mem_width;
    logic [2:0] dec_op_type;
    logic [1:0] dec_operand1;
    logic [1:0] dec_operand2;
    logic [xlen-1:0] dec_imm;
    logic dec_wb_en;
    logic [iw-1:0] dec_rs1;
    logic [iw-1:0] dec_rs2;
    logic [iw-1:0] dec_rd;
    logic dec_valid;
    logic dec_ready;
    logic [xlen-1:0] ix_ip_pc;
    logic [iw-1:0] ix_ip_dst;
    logic ix_ip_wb_en;
    logic [3:0] ix_ip_op;
    logic ix_ip_option;
    logic ix_ip_truncate;
    logic [xlen-1:0] ix_ip_operand1;
    logic [xlen-1:0] ix_ip_operand2;
    logic ix_ip_valid;
    logic ix_ip_ready;
    logic [xlen-1:0] ip_ix_forwarding;
    logic [iw-1:0] ip_wb_dst;
    logic [xlen-1:0] ip_wb_result;
    logic ip_wb_wb_en;
    logic ip_wb_valid;
    logic [iw-1:0] lsp_wb_dst;
    logic [xlen-1:0] lsp_wb_result;
    logic lsp_wb_wb_en;
    logic lsp_wb_valid;
    logic lsp_mem_wb_en;
    logic [iw-1:0] lsp_mem_dst;
    logic [xlen-1:0] ix_lsp_pc;
    logic [iw-1:0] ix_lsp_dst;
    logic ix_lsp_wb_en;
    logic [xlen-1:0] ix_lsp_base;
    logic [issue_pkg::lsp_offset_w-1:0] ix_lsp_offset;
    logic [xlen-1:0] ix_lsp_source;
    logic ix_lsp_mem_sign;
    logic [1:0] ix_lsp_mem_width;
    logic ix_lsp_valid;
    logic ix_lsp_ready;
    int check_count;
    int error_count;

    logic [xlen-1:0] rf [32];
    logic [31:0] rng_state;

    tb_clock #(.period(period), .reset_cycles(reset_cycles)) u_tb_clock (.clk(clk), .rst(rst));

    issue_stage #(.xlen(xlen)) u_issue_stage (.*);

    issue_checker #(.xlen(xlen)) u_issue_checker (.*);

    // Register x0 holds garbage so the stage must zero it
    initial begin
        for (int i = 0; i < 32; i++) begin
            rf[i] = {32'(i) * 32'h9e3779b9 ^ 32'h5a5a0f0f, ~(32'(i) * 32'h85ebca6b)};
        end
    end

    assign rf_rdata0 = rf[rf_rsrc0];
    assign rf_rdata1 = rf[rf_rsrc1];

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic new_instruction();
        logic [31:0] r;
        r = rand32();
        dec_pc = {rand32(), rand32() & 32'hffff_fffc};
        dec_imm = {rand32(), rand32()};
        dec_op = r[3:0];
        dec_option = r[4];
        dec_truncate = r[5];
        dec_mem_sign = r[6];
        dec_mem_width = r[8:7];
        dec_wb_en = r[9] | r[10];
        dec_operand1 = r[12:11];
        dec_operand2 = 2'((r >> 13) % 3);
        dec_op_type = 3'((r >> 16) % 3);
        // Indices from x0..x7 so hazards are common
        dec_rs1 = iw'(r[22:20]);
        dec_rs2 = iw'(r[25:23]);
        dec_rd = iw'(r[28:26]);
    endtask

    task automatic set_forwarding(input logic active);
        logic [31:0] r;
        r = rand32();
        ip_wb_valid = active & r[0];
        ip_wb_wb_en = r[1];
        ip_wb_dst = iw'(r[4:2]);
        lsp_wb_valid = active & r[5];
        lsp_wb_wb_en = r[6];
        lsp_wb_dst = iw'(r[9:7]);
        lsp_mem_wb_en = active & r[10] & r[11];
        lsp_mem_dst = iw'(r[14:12]);
        ip_ix_forwarding = active ? {rand32(), rand32()} : '0;
        ip_wb_result = {rand32(), rand32()};
        lsp_wb_result = {rand32(), rand32()};
    endtask

    task automatic drive_cycle(input int phase, input logic pending);
        logic [31:0] r;
        r = rand32();
        pipe_flush = (phase == 5) && (r[2:0] == 3'd0);
        ix_ip_ready = (phase >= 4) ? (r[3] | r[4]) : 1'b1;
        ix_lsp_ready = (phase >= 4) ? (r[5] | r[6]) : 1'b1;
        set_forwarding(phase >= 3);
        // A stalled instruction stays on the decode outputs
        if (!pending) begin
            dec_valid = (phase >= 2) && (r[9:8] != 2'd0);
            new_instruction();
        end
    endtask

    task automatic run_test(input int n, input int phase, input string name);
        int c0;
        int e0;
        logic pending;
        c0 = check_count;
        e0 = error_count;
        repeat (n) begin
            @(negedge clk);
            pending = dec_valid && !dec_ready;
            @(posedge clk);
            #drive_delay;
            drive_cycle(phase, pending);
        end
        $display("test %0d %s: %0d checks, %0d errors", phase, name,
                check_count - c0, error_count - e0);
    endtask

    initial begin
        rng_state = 32'd46445;
        pipe_flush = 1'b0;
        dec_valid = 1'b0;
        ix_ip_ready = 1'b1;
        ix_lsp_ready = 1'b1;
        new_instruction();
        set_forwarding(1'b0);
        run_test(reset_cycles + idle_cycles, 1, "reset and idle");
        run_test(basic_cycles, 2, "register file operands");
        run_test(fwd_cycles, 3, "forwarding and stalls");
        run_test(bp_cycles, 4, "back-pressure and WAW");
        run_test(flush_cycles, 5, "pipe flush");
        $display("tests 5, checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(total_cycles * period * 2);
        $display("timeout: the test sequence did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
issue_pkg.sv
operand_if.sv
operand_forward.sv
issue_ctrl.sv
issue_slot.sv
issue_stage.sv
tb_clock.sv
issue_checker.sv
tb_issue_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_issue_stage
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Passes only when the pass line appears in the simulation output
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
